// ==== dv/dispatch_stimulus.txt ====
// instr pc br{cond,dir} br_target | imm rd rs1 rs2 funct3 fmt{r,i,s,b,u,j}
// {src1,src2,dst} {sub,sra_srai,lui,jalr,ls}, all hex, one instruction per line
002081b3 00001000 0 00000000 00000000 03 01 02 0 20 7 00 // add x3, x1, x2
407302b3 00001004 0 00000000 00000000 05 06 07 0 20 7 10 // sub x5, x6, x7
40a4d433 00001008 0 00000000 00000000 08 09 0a 5 20 7 08 // sra x8, x9, x10
ffb10093 0000100c 0 00000000 fffffffb 01 02 1b 0 10 5 00 // addi x1, x2, -5
4032d213 00001010 0 00000000 00000403 04 05 03 5 10 5 08 // srai x4, x5, 3
0083a303 00001014 0 00000000 00000008 06 07 08 2 10 5 01 // lw x6, 8(x7)
ff0100e7 00001018 0 00000000 fffffff0 01 02 10 0 10 5 02 // jalr x1, -16(x2)
fe952e23 0000101c 0 00000000 fffffffc 1c 0a 09 2 08 6 01 // sw x9, -4(x10)
fe208ce3 00001020 3 00001018 fffffff8 19 01 02 0 04 6 00 // beq x1, x2, -8
00419863 00001024 2 00001034 00000010 10 03 04 1 04 6 00 // bne x3, x4, 16
123452b7 00001028 0 00000000 12345000 05 08 03 5 02 1 04 // lui x5, 0x12345
fffff397 0000102c 0 00000000 fffff000 07 1f 1f 7 02 1 00 // auipc x7, 0xfffff
ffdff06f 00001030 0 00000000 fffffffc 00 1f 1d 7 01 1 00 // jal x0, -4
002081ab 00001034 0 00000000 00000000 03 01 02 0 00 0 00 // custom-1, unknown opcode

// ==== sources.f ====
logic/rv_isa_pkg.sv
logic/core_types_pkg.sv
logic/instr_fifo.sv
logic/decode.sv
logic/dispatch.sv
logic/dispatch_top.sv
dv/dispatch_assertions.sv
dv/tb_dispatch_top.sv

// ==== run.sh ====
#!/bin/sh
# builds and runs the dispatch testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_dispatch_top \
    -f sources.f -Mdir obj_dir -o sim_dispatch
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_dispatch)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "=== PASS ==="; then
    exit 0
fi
echo "pass message not found"
exit 1

// ==== dv/tb_dispatch_top.sv ====
`default_nettype none

module tb_dispatch_top;
    import rv_isa_pkg::*;
    import core_types_pkg::*;

    localparam int ififo_depth     = 4;
    localparam int n_lines         = 14;
    localparam int words_per_line  = 12;
    localparam int load_line       = 5;    // lw x6, 8(x7) in the stimulus file
    localparam int random_count    = 60;
    localparam int stream_timeout  = 2000;
    localparam int drain_timeout   = 200;
    localparam int latency_timeout = 8;

    logic         clk = 1'b0;
    logic         rst;
    logic         fetch_push;
    ififo_entry_t fetch_entry;
    logic         ififo_full;
    logic         int_stall;
    logic         ls_stall;
    logic         int_issue;
    logic         ls_issue;
    addr_t        issue_pc;
    imm_t         issue_imm;
    funct3_t      issue_funct3;
    reg_idx_t     issue_rs1;
    reg_idx_t     issue_rs2;
    reg_idx_t     issue_rd;
    logic         src1_valid;
    logic         src2_valid;
    logic         dst_valid;
    logic         is_r_type;
    logic         is_i_type;
    logic         is_s_type;
    logic         is_b_type;
    logic         is_u_type;
    logic         is_j_type;
    logic         is_sub;
    logic         is_sra_srai;
    logic         is_lui;
    logic         is_jalr;
    logic         is_cond_br;
    logic         br_dir_pred;
    addr_t        br_target_pred;

    logic [31:0] stim [n_lines*words_per_line]; // 12 hex words per instruction
    logic [31:0] lfsr;

    int    exp_line_q[$]; // stimulus line of each entry still in flight
    addr_t exp_pc_q[$];
    addr_t exp_tgt_q[$];

    dispatch_top #(
        .ififo_depth (ififo_depth)
    ) uut (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32 + x^22 + x^2 + x + 1
    endfunction

    task automatic next_bit(output logic b);
        lfsr = lfsr_step(lfsr);
        b = lfsr[0];
    endtask

    task automatic abort_sim();
        $display("=== FAIL ===");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic value_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
        abort_sim();
    endtask

    task automatic report_error(input string what);
        $display("ERROR: %s", what);
        abort_sim();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else value_mismatch(name, got, exp);
    endtask

    task automatic tick();
        @(posedge clk);
        #1; // inputs change just after the edge
    endtask

    // drives one entry for the next edge and records what should come out
    task automatic push_line(input int line, input logic [31:0] offset);
        int b;
        b = line * words_per_line;
        fetch_push  = 1'b1;
        fetch_entry = {stim[b], stim[b+1] + offset, stim[b+2][1], stim[b+2][0],
                       stim[b+3] + offset};
        exp_line_q.push_back(line);
        exp_pc_q.push_back(stim[b+1] + offset);
        exp_tgt_q.push_back(stim[b+3] + offset);
    endtask

    task automatic check_packet();
        int    line;
        int    b;
        addr_t exp_pc;
        addr_t exp_tgt;
        assert (!(int_issue && ls_issue)) else report_error("both issue sides fired at once");
        assert (exp_line_q.size() > 0) else report_error("issue pulse with nothing in flight");
        line    = exp_line_q.pop_front();
        exp_pc  = exp_pc_q.pop_front();
        exp_tgt = exp_tgt_q.pop_front();
        b       = line * words_per_line;
        check_value("issue_pc", issue_pc, exp_pc);
        check_value("br_target_pred", br_target_pred, exp_tgt);
        check_value("{is_cond_br,br_dir_pred}", 32'({is_cond_br, br_dir_pred}), stim[b+2]);
        check_value("issue_imm", issue_imm, stim[b+4]);
        check_value("issue_rd", 32'(issue_rd), stim[b+5]);
        check_value("issue_rs1", 32'(issue_rs1), stim[b+6]);
        check_value("issue_rs2", 32'(issue_rs2), stim[b+7]);
        check_value("issue_funct3", 32'(issue_funct3), stim[b+8]);
        check_value("{is_r_type,is_i_type,is_s_type,is_b_type,is_u_type,is_j_type}",
                    32'({is_r_type, is_i_type, is_s_type, is_b_type, is_u_type, is_j_type}),
                    stim[b+9]);
        check_value("{src1_valid,src2_valid,dst_valid}",
                    32'({src1_valid, src2_valid, dst_valid}), stim[b+10]);
        // ls_issue in the last bit also checks the routing
        check_value("{is_sub,is_sra_srai,is_lui,is_jalr,ls_issue}",
                    32'({is_sub, is_sra_srai, is_lui, is_jalr, ls_issue}), stim[b+11]);
    endtask

    always @(negedge clk) begin
        if (!rst && (int_issue || ls_issue)) begin
            check_packet();
        end
    end

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (exp_line_q.size() > 0) begin
            assert (cycles < drain_timeout) else report_error("entries never drained");
            tick();
            cycles++;
        end
    endtask

    // pushes whenever the ififo has room, until every entry has issued
    task automatic run_stream(input int count, input bit random_stalls);
        int   pushed;
        int   cycles;
        logic bit_a;
        logic bit_b;
        pushed = 0;
        cycles = 0;
        while (pushed < count || exp_line_q.size() > 0) begin
            if (random_stalls) begin
                next_bit(bit_a);
                next_bit(bit_b);
                int_stall = bit_a & bit_b;
                next_bit(bit_a);
                next_bit(bit_b);
                ls_stall = bit_a & bit_b;
            end
            if (pushed < count && !ififo_full) begin
                push_line(pushed % n_lines, 32'(pushed) << 8);
                pushed++;
            end else begin
                fetch_push = 1'b0;
            end
            tick();
            cycles++;
            assert (cycles < stream_timeout) else report_error("stream did not complete");
        end
        fetch_push = 1'b0;
        int_stall  = 1'b0;
        ls_stall   = 1'b0;
    endtask

    initial begin
        int edges;
        rst         = 1'b1;
        fetch_push  = 1'b0;
        fetch_entry = '0;
        int_stall   = 1'b0;
        ls_stall    = 1'b0;
        lfsr        = 32'h97726beb;
        $readmemh("dv/dispatch_stimulus.txt", stim);
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // quiet after reset
        repeat (4) begin
            assert (!int_issue && !ls_issue) else report_error("issue pulse before any push");
            tick();
        end

        // latency of a single push into the empty, unstalled path
        push_line(0, 32'h0);
        tick();
        fetch_push = 1'b0;
        edges = 1;
        while (!(int_issue || ls_issue)) begin
            assert (edges < latency_timeout) else report_error("first entry never issued");
            tick();
            edges++;
        end
        check_value("issue_latency", 32'(edges), 32'd2); // counts the push edge and the pop edge
        wait_drained();

        run_stream(n_lines, 1'b0);      // every format once
        run_stream(random_count, 1'b1);  // order under random stalls

        // a stalled load at the head blocks everything behind it
        ls_stall = 1'b1;
        for (int k = 0; k < ififo_depth; k++) begin
            assert (!ififo_full) else report_error("ififo full too early");
            push_line((load_line + k) % n_lines, 32'h0010_0000);
            tick();
        end
        fetch_push = 1'b0;
        repeat (3) begin
            check_value("ififo_full", 32'(ififo_full), 32'd1);
            assert (!int_issue && !ls_issue) else report_error("issue past a stalled load");
            tick();
        end
        ls_stall = 1'b0;
        wait_drained();

        repeat (3) tick();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/dispatch_assertions.sv ====
`default_nettype none

module dispatch_assertions (
    input logic clk,
    input logic rst,
    input logic fetch_push,
    input logic ififo_full,
    input logic ififo_pop,
    input logic int_issue,
    input logic ls_issue
);

    issue_one_side: assert property (@(posedge clk) disable iff (rst)
        !(int_issue && ls_issue))
        else $error("int_issue and ls_issue high in the same cycle");

    // fetch has to hold while the ififo is full
    no_push_when_full: assert property (@(posedge clk) disable iff (rst)
        !(fetch_push && ififo_full))
        else $error("push while ififo_full is high");

    issue_after_pop: assert property (@(posedge clk) disable iff (rst)
        (int_issue || ls_issue) |-> $past(ififo_pop)) // each issue cycle has its own pop
        else $error("issue pulse without a pop in the previous cycle");

endmodule

bind dispatch_top dispatch_assertions u_dispatch_assertions (
    .clk        (clk),
    .rst        (rst),
    .fetch_push (fetch_push),
    .ififo_full (ififo_full),
    .ififo_pop  (ififo_pop),
    .int_issue  (int_issue),
    .ls_issue   (ls_issue)
);

`default_nettype wire

// ==== logic/dispatch_top.sv ====
`default_nettype none

module dispatch_top #(
    parameter int ififo_depth = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         fetch_push,
    input  core_types_pkg::ififo_entry_t fetch_entry,
    output logic                         ififo_full,
    input  logic                         int_stall,
    input  logic                         ls_stall,
    output logic                         int_issue,
    output logic                         ls_issue,
    output core_types_pkg::addr_t        issue_pc,
    output core_types_pkg::imm_t         issue_imm,
    output rv_isa_pkg::funct3_t          issue_funct3,
    output rv_isa_pkg::reg_idx_t         issue_rs1,
    output rv_isa_pkg::reg_idx_t         issue_rs2,
    output rv_isa_pkg::reg_idx_t         issue_rd,
    output logic                         src1_valid,
    output logic                         src2_valid,
    output logic                         dst_valid,
    output logic                         is_r_type,
    output logic                         is_i_type,
    output logic                         is_s_type,
    output logic                         is_b_type,
    output logic                         is_u_type,
    output logic                         is_j_type,
    output logic                         is_sub,
    output logic                         is_sra_srai,
    output logic                         is_lui,
    output logic                         is_jalr,
    output logic                         is_cond_br,
    output logic                         br_dir_pred,
    output core_types_pkg::addr_t        br_target_pred
);
    import rv_isa_pkg::*;
    import core_types_pkg::*;

    ififo_entry_t ififo_head;
    logic         ififo_empty;
    logic         ififo_pop;

    // decoded head, combinational
    logic     dec_src1_valid;
    logic     dec_src2_valid;
    logic     dec_dst_valid;
    imm_t     dec_imm;
    addr_t    dec_pc;
    funct3_t  dec_funct3;
    reg_idx_t dec_rs1;
    reg_idx_t dec_rs2;
    reg_idx_t dec_rd;
    logic     dec_is_r_type;
    logic     dec_is_i_type;
    logic     dec_is_s_type;
    logic     dec_is_b_type;
    logic     dec_is_u_type;
    logic     dec_is_j_type;
    logic     dec_is_sub;
    logic     dec_is_sra_srai;
    logic     dec_is_lui;
    logic     dec_is_jalr;
    logic     dec_is_int_instr;
    logic     dec_is_ls_instr;
    logic     dec_is_cond_br;
    logic     dec_br_dir_pred;
    addr_t    dec_br_target_pred;

    instr_fifo #(
        .ififo_depth (ififo_depth)
    ) u_instr_fifo (
        .clk        (clk),
        .rst        (rst),
        .push       (fetch_push),
        .push_entry (fetch_entry),
        .pop        (ififo_pop),
        .head       (ififo_head),
        .empty      (ififo_empty),
        .full       (ififo_full)
    );

    decode u_decode (
        .ififo_dispatch_data (ififo_head),
        .src1_valid          (dec_src1_valid),
        .src2_valid          (dec_src2_valid),
        .dst_valid           (dec_dst_valid),
        .imm                 (dec_imm),
        .pc                  (dec_pc),
        .funct3              (dec_funct3),
        .rs1                 (dec_rs1),
        .rs2                 (dec_rs2),
        .rd                  (dec_rd),
        .is_r_type           (dec_is_r_type),
        .is_i_type           (dec_is_i_type),
        .is_s_type           (dec_is_s_type),
        .is_b_type           (dec_is_b_type),
        .is_u_type           (dec_is_u_type),
        .is_j_type           (dec_is_j_type),
        .is_sub              (dec_is_sub),
        .is_sra_srai         (dec_is_sra_srai),
        .is_lui              (dec_is_lui),
        .is_jalr             (dec_is_jalr),
        .is_int_instr        (dec_is_int_instr),
        .is_ls_instr         (dec_is_ls_instr),
        .is_cond_br          (dec_is_cond_br),
        .br_dir_pred         (dec_br_dir_pred),
        .br_target_pred      (dec_br_target_pred)
    );

    dispatch u_dispatch (
        .clk                (clk),
        .rst                (rst),
        .ififo_empty        (ififo_empty),
        .ififo_pop          (ififo_pop),
        .int_stall          (int_stall),
        .ls_stall           (ls_stall),
        .dec_src1_valid     (dec_src1_valid),
        .dec_src2_valid     (dec_src2_valid),
        .dec_dst_valid      (dec_dst_valid),
        .dec_imm            (dec_imm),
        .dec_pc             (dec_pc),
        .dec_funct3         (dec_funct3),
        .dec_rs1            (dec_rs1),
        .dec_rs2            (dec_rs2),
        .dec_rd             (dec_rd),
        .dec_is_r_type      (dec_is_r_type),
        .dec_is_i_type      (dec_is_i_type),
        .dec_is_s_type      (dec_is_s_type),
        .dec_is_b_type      (dec_is_b_type),
        .dec_is_u_type      (dec_is_u_type),
        .dec_is_j_type      (dec_is_j_type),
        .dec_is_sub         (dec_is_sub),
        .dec_is_sra_srai    (dec_is_sra_srai),
        .dec_is_lui         (dec_is_lui),
        .dec_is_jalr        (dec_is_jalr),
        .dec_is_int_instr   (dec_is_int_instr),
        .dec_is_ls_instr    (dec_is_ls_instr),
        .dec_is_cond_br     (dec_is_cond_br),
        .dec_br_dir_pred    (dec_br_dir_pred),
        .dec_br_target_pred (dec_br_target_pred),
        .int_issue          (int_issue),
        .ls_issue           (ls_issue),
        .issue_pc           (issue_pc),
        .issue_imm          (issue_imm),
        .issue_funct3       (issue_funct3),
        .issue_rs1          (issue_rs1),
        .issue_rs2          (issue_rs2),
        .issue_rd           (issue_rd),
        .src1_valid         (src1_valid),
        .src2_valid         (src2_valid),
        .dst_valid          (dst_valid),
        .is_r_type          (is_r_type),
        .is_i_type          (is_i_type),
        .is_s_type          (is_s_type),
        .is_b_type          (is_b_type),
        .is_u_type          (is_u_type),
        .is_j_type          (is_j_type),
        .is_sub             (is_sub),
        .is_sra_srai        (is_sra_srai),
        .is_lui             (is_lui),
        .is_jalr            (is_jalr),
        .is_cond_br         (is_cond_br),
        .br_dir_pred        (br_dir_pred),
        .br_target_pred     (br_target_pred)
    );

endmodule

`default_nettype wire

// ==== logic/dispatch.sv ====
`default_nettype none

module dispatch (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ififo_empty,
    output logic                  ififo_pop,
    input  logic                  int_stall,
    input  logic                  ls_stall,
    input  logic                  dec_src1_valid,
    input  logic                  dec_src2_valid,
    input  logic                  dec_dst_valid,
    input  core_types_pkg::imm_t  dec_imm,
    input  core_types_pkg::addr_t dec_pc,
    input  rv_isa_pkg::funct3_t   dec_funct3,
    input  rv_isa_pkg::reg_idx_t  dec_rs1,
    input  rv_isa_pkg::reg_idx_t  dec_rs2,
    input  rv_isa_pkg::reg_idx_t  dec_rd,
    input  logic                  dec_is_r_type,
    input  logic                  dec_is_i_type,
    input  logic                  dec_is_s_type,
    input  logic                  dec_is_b_type,
    input  logic                  dec_is_u_type,
    input  logic                  dec_is_j_type,
    input  logic                  dec_is_sub,
    input  logic                  dec_is_sra_srai,
    input  logic                  dec_is_lui,
    input  logic                  dec_is_jalr,
    input  logic                  dec_is_int_instr,
    input  logic                  dec_is_ls_instr,
    input  logic                  dec_is_cond_br,
    input  logic                  dec_br_dir_pred,
    input  core_types_pkg::addr_t dec_br_target_pred,
    output logic                  int_issue,
    output logic                  ls_issue,
    output core_types_pkg::addr_t issue_pc,
    output core_types_pkg::imm_t  issue_imm,
    output rv_isa_pkg::funct3_t   issue_funct3,
    output rv_isa_pkg::reg_idx_t  issue_rs1,
    output rv_isa_pkg::reg_idx_t  issue_rs2,
    output rv_isa_pkg::reg_idx_t  issue_rd,
    output logic                  src1_valid,
    output logic                  src2_valid,
    output logic                  dst_valid,
    output logic                  is_r_type,
    output logic                  is_i_type,
    output logic                  is_s_type,
    output logic                  is_b_type,
    output logic                  is_u_type,
    output logic                  is_j_type,
    output logic                  is_sub,
    output logic                  is_sra_srai,
    output logic                  is_lui,
    output logic                  is_jalr,
    output logic                  is_cond_br,
    output logic                  br_dir_pred,
    output core_types_pkg::addr_t br_target_pred
);

    // the head may only leave when its own issue side can take it
    assign ififo_pop = !ififo_empty
                    && ((dec_is_ls_instr && !ls_stall) || (dec_is_int_instr && !int_stall));

    always_ff @(posedge clk) begin
        if (rst) begin
            int_issue <= 1'b0;
            ls_issue  <= 1'b0;
        end else begin
            int_issue <= ififo_pop && dec_is_int_instr; // single-cycle pulse
            ls_issue  <= ififo_pop && dec_is_ls_instr;
        end
    end

    // packet is only meaningful while an issue pulse is high
    always_ff @(posedge clk) begin
        if (ififo_pop) begin
            issue_pc       <= dec_pc;
            issue_imm      <= dec_imm;
            issue_funct3   <= dec_funct3;
            issue_rs1      <= dec_rs1;
            issue_rs2      <= dec_rs2;
            issue_rd       <= dec_rd;
            src1_valid     <= dec_src1_valid;
            src2_valid     <= dec_src2_valid;
            dst_valid      <= dec_dst_valid;
            is_r_type      <= dec_is_r_type;
            is_i_type      <= dec_is_i_type;
            is_s_type      <= dec_is_s_type;
            is_b_type      <= dec_is_b_type;
            is_u_type      <= dec_is_u_type;
            is_j_type      <= dec_is_j_type;
            is_sub         <= dec_is_sub;
            is_sra_srai    <= dec_is_sra_srai;
            is_lui         <= dec_is_lui;
            is_jalr        <= dec_is_jalr;
            is_cond_br     <= dec_is_cond_br;
            br_dir_pred    <= dec_br_dir_pred;
            br_target_pred <= dec_br_target_pred;
        end
    end

endmodule

`default_nettype wire

// ==== logic/decode.sv ====
`default_nettype none

module decode (
    input  core_types_pkg::ififo_entry_t ififo_dispatch_data,
    output logic                         src1_valid, // register operand exists
    output logic                         src2_valid,
    output logic                         dst_valid,
    output core_types_pkg::imm_t         imm,
    output core_types_pkg::addr_t        pc,
    output rv_isa_pkg::funct3_t          funct3,
    output rv_isa_pkg::reg_idx_t         rs1,
    output rv_isa_pkg::reg_idx_t         rs2,
    output rv_isa_pkg::reg_idx_t         rd,
    output logic                         is_r_type,
    output logic                         is_i_type,
    output logic                         is_s_type,
    output logic                         is_b_type,
    output logic                         is_u_type, // lui, auipc
    output logic                         is_j_type, // jal
    output logic                         is_sub,
    output logic                         is_sra_srai,
    output logic                         is_lui,
    output logic                         is_jalr,
    output logic                         is_int_instr,
    output logic                         is_ls_instr,
    output logic                         is_cond_br,
    output logic                         br_dir_pred,
    output core_types_pkg::addr_t        br_target_pred
);
    import rv_isa_pkg::*;
    import core_types_pkg::*;

    instr_t  instr;
    opcode_t opcode;
    logic    funct7_b5; // selects sub and arithmetic right shift

    imm_t imm_i;
    imm_t imm_s;
    imm_t imm_b;
    imm_t imm_u;
    imm_t imm_j;

    assign {instr, pc, is_cond_br, br_dir_pred, br_target_pred} = ififo_dispatch_data;

    assign opcode    = instr[6:0];
    assign rd        = instr[11:7];
    assign funct3    = instr[14:12];
    assign rs1       = instr[19:15];
    assign rs2       = instr[24:20];
    assign funct7_b5 = instr[30];

    assign imm_i = i_imm(instr);
    assign imm_s = s_imm(instr);
    assign imm_b = b_imm(instr);
    assign imm_u = u_imm(instr);
    assign imm_j = j_imm(instr);

    // exactly one format flag per known opcode, none for the rest
    assign is_r_type = (opcode == op_opcode);
    assign is_i_type = (opcode == op_imm_opcode) || (opcode == load_opcode)
                    || (opcode == jalr_opcode);
    assign is_s_type = (opcode == store_opcode);
    assign is_b_type = (opcode == branch_opcode);
    assign is_u_type = (opcode == lui_opcode) || (opcode == auipc_opcode);
    assign is_j_type = (opcode == jal_opcode);

    assign src1_valid = is_r_type || is_i_type || is_s_type || is_b_type;
    assign src2_valid = is_r_type || is_s_type || is_b_type;
    assign dst_valid  = is_r_type || is_i_type || is_u_type || is_j_type;

    assign imm = is_i_type ? imm_i :
                 is_s_type ? imm_s :
                 is_b_type ? imm_b :
                 is_u_type ? imm_u :
                 is_j_type ? imm_j :
                             '0;    // r-type and unknown opcodes

    assign is_sub      = is_r_type && (funct3 == add_sub_funct3) && funct7_b5;
    assign is_sra_srai = ((opcode == op_opcode) || (opcode == op_imm_opcode))
                      && (funct3 == srl_sra_funct3) && funct7_b5;
    assign is_lui      = (opcode == lui_opcode);
    assign is_jalr     = (opcode == jalr_opcode);

    assign is_ls_instr  = (opcode == load_opcode) || (opcode == store_opcode);
    assign is_int_instr = !is_ls_instr; // unknown opcodes go to the int side

endmodule

`default_nettype wire

// ==== logic/instr_fifo.sv ====
`default_nettype none

module instr_fifo #(
    parameter int ififo_depth = 4 // power of two
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         push,
    input  core_types_pkg::ififo_entry_t push_entry,
    input  logic                         pop,
    output core_types_pkg::ififo_entry_t head,
    output logic                         empty,
    output logic                         full
);
    import core_types_pkg::*;

    localparam int ptr_width = $clog2(ififo_depth);
    localparam logic [ptr_width:0] count_full = (ptr_width + 1)'(ififo_depth);

    ififo_entry_t mem [ififo_depth];

    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [ptr_width:0]   count; // one extra bit so full and empty differ

    logic do_push;
    logic do_pop;

    assign do_push = push && !full; // push into a full fifo is dropped
    assign do_pop  = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == count_full);
    assign head  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1; // wraps naturally
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/core_types_pkg.sv ====
`default_nettype none

package core_types_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] addr_t;
    typedef logic [xlen-1:0] imm_t;

    // instr, pc, is_cond_br, br_dir_pred, br_target_pred
    localparam int ififo_entry_width = rv_isa_pkg::instr_width + xlen + 1 + 1 + xlen;

    typedef logic [ififo_entry_width-1:0] ififo_entry_t;

endpackage

`default_nettype wire

// ==== logic/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    localparam int instr_width   = 32;
    localparam int opcode_width  = 7;
    localparam int funct3_width  = 3;
    localparam int reg_idx_width = 5;

    typedef logic [instr_width-1:0]   instr_t;
    typedef logic [opcode_width-1:0]  opcode_t;
    typedef logic [funct3_width-1:0]  funct3_t;
    typedef logic [reg_idx_width-1:0] reg_idx_t;

    // base opcode map, bits [6:0]
    localparam opcode_t op_opcode     = 7'b0110011;
    localparam opcode_t op_imm_opcode = 7'b0010011;
    localparam opcode_t load_opcode   = 7'b0000011;
    localparam opcode_t store_opcode  = 7'b0100011;
    localparam opcode_t branch_opcode = 7'b1100011;
    localparam opcode_t lui_opcode    = 7'b0110111;
    localparam opcode_t auipc_opcode  = 7'b0010111;
    localparam opcode_t jal_opcode    = 7'b1101111;
    localparam opcode_t jalr_opcode   = 7'b1100111;

    localparam funct3_t add_sub_funct3 = 3'b000; // add, addi, sub
    localparam funct3_t srl_sra_funct3 = 3'b101; // srl(i), sra(i)

    // sign-extended immediates, one per encoding format
    function automatic logic [31:0] i_imm(input instr_t instr);
        return {{20{instr[31]}}, instr[31:20]};
    endfunction

    function automatic logic [31:0] s_imm(input instr_t instr);
        return {{20{instr[31]}}, instr[31:25], instr[11:7]};
    endfunction

    function automatic logic [31:0] b_imm(input instr_t instr);
        return {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    endfunction

    function automatic logic [31:0] u_imm(input instr_t instr);
        return {instr[31:12], 12'b0};
    endfunction

    function automatic logic [31:0] j_imm(input instr_t instr);
        return {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    endfunction

endpackage

`default_nettype wire
